// File: verilog/tau_cfg_pkg.sv
package tau_cfg_pkg;

	// ========================================================================
	// Work dimensions
	// ========================================================================
	// Number of work dimensions
	localparam int VDIM = 2;
	// Selects one of the VDIM axes
	localparam int VDIM_BW = 1;
	// One offset in a single dimension
	localparam int WORK_BW = 8;

	// ========================================================================
	// Instructions and warps
	// ========================================================================
	// Instruction configurations held by the accelerator
	localparam int N_ICFG = 4;
	// Must hold N_ICFG itself, since id_end is exclusive
	localparam int NCFG_BW = 3;
	// Warp ids wrap past the last of these slots
	localparam int MAX_WARP = 8;
	localparam int WID_BW = 3;

	// ========================================================================
	// Sub-block shuffle and dual issue
	// ========================================================================
	// Shuffle orders run from 0 up to WORK_BW-1
	localparam int CCV_BW = 3;
	// Bit position ORed in on the second dual half
	localparam int CW_BW = 3;

endpackage

// File: verilog/looper_types_pkg.sv
package looper_types_pkg;
	import tau_cfg_pkg::*;

	// Offset in one dimension for block and accumulator offsets
	typedef logic [WORK_BW-1:0] work_t;

	// Instruction and warp identifiers
	typedef logic [NCFG_BW-1:0] inst_id_t;
	typedef logic [WID_BW-1:0] warp_id_t;

	// Shift amount of the sub-block shuffle
	typedef logic [CCV_BW-1:0] order_t;

	// Dual issue settings
	typedef logic [CW_BW-1:0] dual_pos_t;
	typedef logic [VDIM_BW-1:0] axis_t;

	// Combiner FSM
	typedef enum logic {
		ISSUE_IDLE,
		ISSUE_RUN
	} issue_state_t;

endpackage

// File: verilog/looper_ifs.sv
`timescale 1ns/1ps

// Combiner to block offset walker
interface walk_if import tau_cfg_pkg::*, looper_types_pkg::*; ();
	logic load;
	logic step;
	work_t bofs [VDIM];
	work_t blofs [VDIM];
	logic last;

	modport issue (output load, output step, input bofs, input blofs, input last);
	modport walker (input load, input step, output bofs, output blofs, output last);
endinterface

// Combiner to instruction and warp sequencer
interface seq_if import looper_types_pkg::*; ();
	logic load;
	logic adv;
	inst_id_t id;
	warp_id_t warpid;
	logic half;
	logic id_last;

	modport issue (
		output load, output adv,
		input id, input warpid, input half, input id_last
	);
	modport sequencer (
		input load, input adv,
		output id, output warpid, output half, output id_last
	);
endinterface

// File: verilog/block_offset_walker.sv
`timescale 1ns/1ps

module block_offset_walker import tau_cfg_pkg::*, looper_types_pkg::*; (
	input logic i_clk,
	input logic i_rst,
	input work_t i_bofs [VDIM],
	input work_t i_bgrid_step [VDIM],
	input order_t i_bsub_up_order [VDIM],
	walk_if.walker walk
);

	// Range of the current command already scaled down by the up order
	work_t rng_beg [VDIM];
	work_t rng_end [VDIM];

	// Current position and its distance from the range start
	work_t pos [VDIM];
	work_t lpos [VDIM];
	work_t pos_nxt [VDIM];
	work_t lpos_nxt [VDIM];
	logic [VDIM-1:0] at_end;

	// ========================================================================
	// N-dimensional counter with dimension 0 running fastest
	// ========================================================================
	always_comb begin
		logic carry;
		carry = 1'b1;
		for (int i = 0; i < VDIM; i++) begin
			at_end[i] = pos[i] == work_t'(rng_end[i] - 1'b1);
			pos_nxt[i] = pos[i];
			lpos_nxt[i] = lpos[i];
			if (carry) begin
				if (at_end[i]) begin
					// Wrap and carry into the next dimension
					pos_nxt[i] = rng_beg[i];
					lpos_nxt[i] = '0;
				end else begin
					pos_nxt[i] = pos[i] + 1'b1;
					lpos_nxt[i] = lpos[i] + 1'b1;
					carry = 1'b0;
				end
			end
		end
	end

	assign walk.bofs = pos;
	assign walk.blofs = lpos;
	assign walk.last = &at_end;

	// ========================================================================
	// Registers
	// ========================================================================
	always_ff @(posedge i_clk) begin
		if (walk.load) begin
			for (int i = 0; i < VDIM; i++) begin
				rng_beg[i] <= i_bofs[i] >> i_bsub_up_order[i];
				// Sum wraps at WORK_BW before the shift
				rng_end[i] <= work_t'(i_bofs[i] + i_bgrid_step[i]) >> i_bsub_up_order[i];
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int i = 0; i < VDIM; i++) begin
				pos[i] <= '0;
				lpos[i] <= '0;
			end
		end else if (walk.load) begin
			for (int i = 0; i < VDIM; i++) begin
				pos[i] <= i_bofs[i] >> i_bsub_up_order[i];
				lpos[i] <= '0;
			end
		end else if (walk.step) begin
			pos <= pos_nxt;
			lpos <= lpos_nxt;
		end
	end

endmodule

// File: verilog/warp_id_sequencer.sv
`timescale 1ns/1ps

module warp_id_sequencer import tau_cfg_pkg::*, looper_types_pkg::*; (
	input logic i_clk,
	input logic i_rst,
	input inst_id_t i_id_beg,
	input inst_id_t i_id_end,
	seq_if.sequencer seq
);

	// Instruction range of the current command with an exclusive end
	inst_id_t id_beg_r;
	inst_id_t id_end_r;

	inst_id_t id_r;
	warp_id_t warpid_r;
	logic half_r;

	inst_id_t id_inc;
	warp_id_t warpid_inc;

	// ========================================================================
	// Next values
	// ========================================================================
	assign id_inc = id_r + 1'b1;

	// One warp per block position wrapping at the slot count
	assign warpid_inc = (warpid_r == warp_id_t'(MAX_WARP - 1)) ? '0 : warpid_r + 1'b1;

	assign seq.id = id_r;
	assign seq.warpid = warpid_r;
	assign seq.half = half_r;
	assign seq.id_last = id_inc == id_end_r;

	// ========================================================================
	// Registers
	// ========================================================================
	always_ff @(posedge i_clk) begin
		if (seq.load) begin
			id_beg_r <= i_id_beg;
			id_end_r <= i_id_end;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			id_r <= '0;
			warpid_r <= '0;
			half_r <= 1'b0;
		end else if (seq.load) begin
			id_r <= i_id_beg;
			warpid_r <= '0;
			half_r <= 1'b0;
		end else if (seq.adv) begin
			// Dual half runs fastest
			half_r <= !half_r;
			if (half_r) begin
				if (seq.id_last) begin
					// Last id of this position moves on to the next warp
					id_r <= id_beg_r;
					warpid_r <= warpid_inc;
				end else begin
					id_r <= id_inc;
				end
			end
		end
	end

endmodule

// File: verilog/index_issue.sv
`timescale 1ns/1ps

module index_issue import tau_cfg_pkg::*, looper_types_pkg::*; (
	input logic i_clk,
	input logic i_rst,
	input logic i_src_rdy,
	output logic o_src_ack,
	input work_t i_aofs [VDIM],
	input work_t i_alofs [VDIM],
	input logic i_islast,
	input inst_id_t i_id_ret,
	input axis_t i_dual_axis,
	input dual_pos_t i_dual_order,
	input order_t i_bsub_up_order [VDIM],
	input order_t i_bsub_lo_order [VDIM],
	output logic o_dst_rdy,
	input logic i_dst_ack,
	output inst_id_t o_id,
	output warp_id_t o_warpid,
	output work_t o_bofs [VDIM],
	output work_t o_aofs [VDIM],
	output work_t o_blofs [VDIM],
	output work_t o_alofs [VDIM],
	output logic o_retire,
	output logic o_islast,
	walk_if.issue walk,
	seq_if.issue seq
);

	issue_state_t state, state_nxt;
	logic src_xfer, dst_xfer, rec_final;

	// Command fields held for the whole command
	work_t aofs_r [VDIM];
	work_t alofs_r [VDIM];
	logic islast_r;
	inst_id_t id_ret_r;
	axis_t dual_axis_r;
	dual_pos_t dual_order_r;
	order_t up_r [VDIM];
	order_t lo_r [VDIM];
	work_t dual_bit [VDIM];

	// Bits from lo upward move left by up so that up=2 lo=3 gives AB00CDE
	function automatic work_t vshuf(input work_t v, input order_t up, input order_t lo);
		work_t lm;
		lm = {WORK_BW{1'b1}} << lo;
		return (v & ~lm) | ((v & lm) << up);
	endfunction

	// ========================================================================
	// Handshake and FSM
	// ========================================================================
	assign o_src_ack = state == ISSUE_IDLE;
	assign o_dst_rdy = state == ISSUE_RUN;
	assign src_xfer = i_src_rdy && o_src_ack;
	assign dst_xfer = o_dst_rdy && i_dst_ack;
	assign rec_final = walk.last && seq.id_last && seq.half;

	assign walk.load = src_xfer;
	assign seq.load = src_xfer;
	assign seq.adv = dst_xfer;
	// Block position moves once all ids and both halves are out
	assign walk.step = dst_xfer && seq.half && seq.id_last;

	always_comb begin
		state_nxt = state;
		case (state)
			ISSUE_IDLE: if (i_src_rdy) state_nxt = ISSUE_RUN;
			ISSUE_RUN: if (dst_xfer && rec_final) state_nxt = ISSUE_IDLE;
			default: state_nxt = ISSUE_IDLE;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= ISSUE_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_ff @(posedge i_clk) begin
		if (src_xfer) begin
			aofs_r <= i_aofs;
			alofs_r <= i_alofs;
			islast_r <= i_islast;
			id_ret_r <= i_id_ret;
			dual_axis_r <= i_dual_axis;
			dual_order_r <= i_dual_order;
			up_r <= i_bsub_up_order;
			lo_r <= i_bsub_lo_order;
		end
	end

	// ========================================================================
	// Record fields
	// ========================================================================
	always_comb begin
		for (int i = 0; i < VDIM; i++) begin
			dual_bit[i] = work_t'(dual_axis_r == axis_t'(i) && seq.half) << dual_order_r;
			o_bofs[i] = vshuf(walk.bofs[i], up_r[i], lo_r[i]) | dual_bit[i];
			o_blofs[i] = vshuf(walk.blofs[i], up_r[i], lo_r[i]) | dual_bit[i];
		end
	end

	assign o_aofs = aofs_r;
	assign o_alofs = alofs_r;
	assign o_id = seq.id;
	assign o_warpid = seq.warpid;
	// Shared memory of this id can be freed once the last position is out
	assign o_retire = walk.last && seq.half && (seq.id < id_ret_r);
	assign o_islast = islast_r && rec_final;

endmodule

// File: verilog/accum_warp_looper_index_stage.sv
`timescale 1ns/1ps

module accum_warp_looper_index_stage import tau_cfg_pkg::*, looper_types_pkg::*; (
	input logic i_clk,
	input logic i_rst,
	// Command
	input logic i_src_rdy,
	output logic o_src_ack,
	input work_t i_bofs [VDIM],
	input work_t i_aofs [VDIM],
	input work_t i_alofs [VDIM],
	input logic i_islast,
	input inst_id_t i_id_beg,
	input inst_id_t i_id_end,
	input inst_id_t i_id_ret,
	input work_t i_bgrid_step [VDIM],
	input axis_t i_dual_axis,
	input dual_pos_t i_dual_order,
	input order_t i_bsub_up_order [VDIM],
	input order_t i_bsub_lo_order [VDIM],
	// Issue records
	output logic o_dst_rdy,
	input logic i_dst_ack,
	output inst_id_t o_id,
	output warp_id_t o_warpid,
	output work_t o_bofs [VDIM],
	output work_t o_aofs [VDIM],
	output work_t o_blofs [VDIM],
	output work_t o_alofs [VDIM],
	output logic o_retire,
	output logic o_islast
);

	walk_if u_walk_if ();
	seq_if u_seq_if ();

	// Block positions of the command grid
	block_offset_walker u_walker (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_bofs(i_bofs),
		.i_bgrid_step(i_bgrid_step),
		.i_bsub_up_order(i_bsub_up_order),
		.walk(u_walk_if)
	);

	// Dual half, instruction id and warp id
	warp_id_sequencer u_seq (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_id_beg(i_id_beg),
		.i_id_end(i_id_end),
		.seq(u_seq_if)
	);

	index_issue u_issue (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_src_rdy(i_src_rdy),
		.o_src_ack(o_src_ack),
		.i_aofs(i_aofs),
		.i_alofs(i_alofs),
		.i_islast(i_islast),
		.i_id_ret(i_id_ret),
		.i_dual_axis(i_dual_axis),
		.i_dual_order(i_dual_order),
		.i_bsub_up_order(i_bsub_up_order),
		.i_bsub_lo_order(i_bsub_lo_order),
		.o_dst_rdy(o_dst_rdy),
		.i_dst_ack(i_dst_ack),
		.o_id(o_id),
		.o_warpid(o_warpid),
		.o_bofs(o_bofs),
		.o_aofs(o_aofs),
		.o_blofs(o_blofs),
		.o_alofs(o_alofs),
		.o_retire(o_retire),
		.o_islast(o_islast),
		.walk(u_walk_if),
		.seq(u_seq_if)
	);

endmodule

// File: verification/index_stage_props.sv
`timescale 1ns/1ps

module index_stage_props import tau_cfg_pkg::*, looper_types_pkg::*; (
	input logic i_clk,
	input logic i_rst,
	input logic o_src_ack,
	input logic o_dst_rdy,
	input logic i_dst_ack,
	input inst_id_t o_id,
	input warp_id_t o_warpid,
	input work_t o_bofs [VDIM],
	input work_t o_aofs [VDIM],
	input work_t o_blofs [VDIM],
	input work_t o_alofs [VDIM],
	input logic o_retire,
	input logic o_islast
);

	// All offsets of a record in one vector
	work_t [4*VDIM-1:0] offs;

	always_comb begin
		for (int i = 0; i < VDIM; i++) begin
			offs[4*i] = o_bofs[i];
			offs[4*i+1] = o_blofs[i];
			offs[4*i+2] = o_aofs[i];
			offs[4*i+3] = o_alofs[i];
		end
	end

	// A pending record holds until the receiver takes it
	rec_hold: assert property (@(posedge i_clk) disable iff (i_rst)
		o_dst_rdy && !i_dst_ack |=>
		o_dst_rdy && $stable({o_id, o_warpid, offs, o_retire, o_islast}))
		else $error("Record changed or dropped before it was acknowledged");

	// The stage stays busy while a record waits for the receiver
	cmd_blocked: assert property (@(posedge i_clk) disable iff (i_rst)
		o_dst_rdy && !i_dst_ack |=> !o_src_ack)
		else $error("Stage went idle with a record still pending");

	rst_quiet: assert property (@(posedge i_clk) i_rst |=> !o_dst_rdy)
		else $error("Record offered right after reset");

endmodule

bind accum_warp_looper_index_stage index_stage_props u_props (.*);

// File: verification/tb_accum_warp_looper_index_stage.sv
`timescale 1ns/1ps

module tb_accum_warp_looper_index_stage import tau_cfg_pkg::*, looper_types_pkg::*;;

	// One expected issue record
	typedef struct packed {
		inst_id_t id;
		warp_id_t warpid;
		work_t [VDIM-1:0] bofs;
		work_t [VDIM-1:0] blofs;
		work_t [VDIM-1:0] aofs;
		work_t [VDIM-1:0] alofs;
		logic retire;
		logic islast;
	} rec_t;

	logic i_clk;
	logic i_rst;
	logic i_src_rdy;
	logic o_src_ack;
	work_t i_bofs [VDIM];
	work_t i_aofs [VDIM];
	work_t i_alofs [VDIM];
	logic i_islast;
	inst_id_t i_id_beg;
	inst_id_t i_id_end;
	inst_id_t i_id_ret;
	work_t i_bgrid_step [VDIM];
	axis_t i_dual_axis;
	dual_pos_t i_dual_order;
	order_t i_bsub_up_order [VDIM];
	order_t i_bsub_lo_order [VDIM];
	logic o_dst_rdy;
	logic i_dst_ack;
	inst_id_t o_id;
	warp_id_t o_warpid;
	work_t o_bofs [VDIM];
	work_t o_aofs [VDIM];
	work_t o_blofs [VDIM];
	work_t o_alofs [VDIM];
	logic o_retire;
	logic o_islast;

	int seed;
	int errors;
	int n_checked;
	logic bp_on;
	rec_t exp_q [$];

	accum_warp_looper_index_stage DUT (.*);

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	function automatic int rnd(input int n);
		return ($random(seed) & 32'h7fff_ffff) % n;
	endfunction

	task automatic fail_run(input string why);
		$display("%s at time %0t", why, $time);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("ERROR time=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	// ========================================================================
	// Reference model
	// ========================================================================
	// Low bits below lo stay and the rest moves up by up
	function automatic work_t shuffled(input int v, input int up, input int lo);
		int low;
		low = v % (1 << lo);
		return work_t'(low + ((v - low) << up));
	endfunction

	function automatic void build_expected();
		int first [VDIM];
		int span [VDIM];
		int p [VDIM];
		int n_pos;
		int rem;
		work_t dbit;
		rec_t r;
		n_pos = 1;
		for (int d = 0; d < VDIM; d++) begin
			first[d] = int'(i_bofs[d]) >> i_bsub_up_order[d];
			span[d] = (int'(work_t'(i_bofs[d] + i_bgrid_step[d])) >> i_bsub_up_order[d])
				- first[d];
			n_pos = n_pos * span[d];
		end
		for (int k = 0; k < n_pos; k++) begin
			rem = k;
			for (int d = 0; d < VDIM; d++) begin
				p[d] = first[d] + rem % span[d];
				rem = rem / span[d];
			end
			for (int id = int'(i_id_beg); id < int'(i_id_end); id++) begin
				for (int h = 0; h < 2; h++) begin
					r.id = inst_id_t'(id);
					r.warpid = warp_id_t'(k % MAX_WARP);
					for (int d = 0; d < VDIM; d++) begin
						dbit = (int'(i_dual_axis) == d && h == 1) ?
							work_t'(1 << i_dual_order) : work_t'(0);
						r.bofs[d] = shuffled(p[d], int'(i_bsub_up_order[d]),
							int'(i_bsub_lo_order[d])) | dbit;
						r.blofs[d] = shuffled(p[d] - first[d], int'(i_bsub_up_order[d]),
							int'(i_bsub_lo_order[d])) | dbit;
						r.aofs[d] = i_aofs[d];
						r.alofs[d] = i_alofs[d];
					end
					r.retire = k == n_pos - 1 && h == 1 && id < int'(i_id_ret);
					r.islast = i_islast && k == n_pos - 1 && id == int'(i_id_end) - 1 && h == 1;
					exp_q.push_back(r);
				end
			end
		end
	endfunction

	// ========================================================================
	// Command side
	// ========================================================================
	task automatic set_cmd(input int b0, input int b1, input int s0, input int s1,
		input int u0, input int u1, input int l0, input int l1,
		input int ib, input int ie, input int ir, input int ax, input int dord, input int isl);
		i_bofs[0] = work_t'(b0);
		i_bofs[1] = work_t'(b1);
		i_bgrid_step[0] = work_t'(s0);
		i_bgrid_step[1] = work_t'(s1);
		i_bsub_up_order[0] = order_t'(u0);
		i_bsub_up_order[1] = order_t'(u1);
		i_bsub_lo_order[0] = order_t'(l0);
		i_bsub_lo_order[1] = order_t'(l1);
		i_aofs[0] = work_t'(b0 * 3 + 1);
		i_aofs[1] = work_t'(b1 * 5 + 2);
		i_alofs[0] = work_t'(s0 + 100);
		i_alofs[1] = work_t'(s1 + 200);
		i_id_beg = inst_id_t'(ib);
		i_id_end = inst_id_t'(ie);
		i_id_ret = inst_id_t'(ir);
		i_dual_axis = axis_t'(ax);
		i_dual_order = dual_pos_t'(dord);
		i_islast = isl != 0;
	endtask

	task automatic randomize_cmd();
		int up;
		int ib;
		for (int d = 0; d < VDIM; d++) begin
			up = rnd(3);
			i_bofs[d] = work_t'(rnd(64));
			// Whole sub-blocks keep the scaled range from being empty
			i_bgrid_step[d] = work_t'((1 << up) * (1 + rnd(4)));
			i_bsub_up_order[d] = order_t'(up);
			i_bsub_lo_order[d] = order_t'(rnd(4));
			i_aofs[d] = work_t'(rnd(256));
			i_alofs[d] = work_t'(rnd(256));
		end
		ib = rnd(N_ICFG);
		i_id_beg = inst_id_t'(ib);
		i_id_end = inst_id_t'(ib + 1 + rnd(N_ICFG - ib));
		i_id_ret = inst_id_t'(rnd(N_ICFG + 1));
		i_dual_axis = axis_t'(rnd(VDIM));
		i_dual_order = dual_pos_t'(rnd(WORK_BW));
		i_islast = rnd(2) == 1;
	endtask

	task automatic send_cmd();
		int cnt;
		cnt = 0;
		i_src_rdy = 1'b1;
		@(negedge i_clk);
		while (!o_src_ack) begin
			cnt++;
			if (cnt > 2000)
				fail_run("Timeout waiting for the command to be accepted");
			@(negedge i_clk);
		end
		@(posedge i_clk);
		#1;
		build_expected();
		i_src_rdy = 1'b0;
	endtask

	task automatic wait_idle();
		int cnt;
		cnt = 0;
		@(negedge i_clk);
		while (exp_q.size() != 0 || !o_src_ack) begin
			cnt++;
			if (cnt > 4000)
				fail_run("Timeout waiting for the stage to drain its records");
			@(negedge i_clk);
		end
		@(posedge i_clk);
		#1;
	endtask

	// ========================================================================
	// Record side
	// ========================================================================
	initial begin
		i_dst_ack = 1'b0;
		forever begin
			@(posedge i_clk);
			#1;
			i_dst_ack = bp_on ? rnd(3) != 0 : 1'b1;
		end
	end

	task automatic compare_record(input rec_t e);
		check("o_id", 32'(o_id), 32'(e.id));
		check("o_warpid", 32'(o_warpid), 32'(e.warpid));
		for (int d = 0; d < VDIM; d++) begin
			check($sformatf("o_bofs[%0d]", d), 32'(o_bofs[d]), 32'(e.bofs[d]));
			check($sformatf("o_blofs[%0d]", d), 32'(o_blofs[d]), 32'(e.blofs[d]));
			check($sformatf("o_aofs[%0d]", d), 32'(o_aofs[d]), 32'(e.aofs[d]));
			check($sformatf("o_alofs[%0d]", d), 32'(o_alofs[d]), 32'(e.alofs[d]));
		end
		check("o_retire", 32'(o_retire), 32'(e.retire));
		check("o_islast", 32'(o_islast), 32'(e.islast));
	endtask

	initial begin
		rec_t e;
		forever begin
			@(negedge i_clk);
			if (!i_rst) begin
				// No new command while records of the current one remain
				if (exp_q.size() != 0)
					check("o_src_ack", 32'(o_src_ack), 32'h0);
				if (o_dst_rdy && i_dst_ack) begin
					if (exp_q.size() == 0)
						fail_run("A record was transferred with none expected");
					e = exp_q.pop_front();
					compare_record(e);
					n_checked++;
				end
			end
		end
	end

	// ========================================================================
	// Test sequence
	// ========================================================================
	initial begin
		seed = 32'h412c_abaa;
		errors = 0;
		n_checked = 0;
		bp_on = 1'b0;
		i_rst = 1'b1;
		i_src_rdy = 1'b0;
		set_cmd(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		repeat (3) @(posedge i_clk);
		#1;
		i_rst = 1'b0;
		@(negedge i_clk);
		check("o_dst_rdy", 32'(o_dst_rdy), 32'h0);
		check("o_src_ack", 32'(o_src_ack), 32'h1);
		@(posedge i_clk);
		#1;

		// Plain order over 3x2 positions and ids 1 and 2
		set_cmd(3, 5, 3, 2, 0, 0, 0, 0, 1, 3, 2, 0, 0, 1);
		send_cmd();
		wait_idle();
		check("record count", 32'(n_checked), 32'd24);

		// Shuffled offsets with the dual bit on axis 1
		n_checked = 0;
		set_cmd(4, 8, 6, 8, 1, 2, 1, 0, 0, 3, 2, 1, 6, 0);
		send_cmd();
		wait_idle();
		check("record count", 32'(n_checked), 32'd36);

		// Twelve positions make the warp id wrap
		n_checked = 0;
		set_cmd(0, 0, 4, 3, 0, 0, 2, 1, 2, 4, 3, 0, 7, 1);
		send_cmd();
		wait_idle();
		check("record count", 32'(n_checked), 32'd48);

		bp_on = 1'b1;
		for (int n = 0; n < 10; n++) begin
			randomize_cmd();
			send_cmd();
		end
		wait_idle();

		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: accum_warp_looper_index_stage.f
verilog/tau_cfg_pkg.sv
verilog/looper_types_pkg.sv
verilog/looper_ifs.sv
verilog/block_offset_walker.sv
verilog/warp_id_sequencer.sv
verilog/index_issue.sv
verilog/accum_warp_looper_index_stage.sv
verification/index_stage_props.sv
verification/tb_accum_warp_looper_index_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_accum_warp_looper_index_stage
FILELIST ?= accum_warp_looper_index_stage.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "All tests passed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
